//--- compile.f
hw/upsp_pkg.sv
hw/crf_if.sv
hw/config_regs.sv
hw/access_control.sv
hw/stream_in.sv
hw/upsampler.sv
hw/out_buffer.sv
hw/stream_out.sv
hw/upsp_top.sv
testbench/tb_upsp.sv

//--- hw/access_control.sv
// One frame per UPSTART; a write-back lost to a concurrent host write is not retried
`timescale 1ns/100ps

module access_control (
	input  logic clk,
	input  logic rst_n,
	crf_if.ctrl  crf,
	input  logic frame_done,
	output logic window,
	output logic frame_clear,
	output logic busy
);
	import upsp_pkg::*;

	ac_state_t state;
	logic      start_req;

	// Start requested by UPSTART without UPEND
	assign start_req = crf.upstart && !crf.upend;

	// IDLE waits for start, RUN lasts until the last beat is taken,
	// FINISH is a single cycle for write-back and clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start_req)
						state <= RUN;
				end
				RUN: begin
					if (frame_done)
						state <= FINISH;
				end
				FINISH: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Datapath only moves inside the time window
	assign window = (state == RUN);

	// Processing flag also covers the write-back cycle
	assign busy = (state != IDLE);

	// Status write-back in FINISH sets UPEND and clears UPSTART
	assign crf.wrt   = (state == FINISH);
	assign crf.waddr = REG_CTRL;
	assign crf.wdata = crf_data_t'(1) << CTRL_UPEND_BIT;

	// Same cycle flushes every datapath stage
	assign frame_clear = (state == FINISH);

endmodule

//--- hw/config_regs.sv
// Host writes win over controller write-back; REG_FRAMES is read-only, only REG_CTRL bits 1:0 exist
`timescale 1ns/100ps

module config_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                host_wr,
	input  upsp_pkg::crf_addr_t host_addr,
	input  upsp_pkg::crf_data_t host_wdata,
	output upsp_pkg::crf_data_t host_rdata,
	crf_if.regs                 crf
);
	import upsp_pkg::*;

	logic      upstart_q;
	logic      upend_q;
	crf_data_t frames_q;
	crf_data_t ctrl_word;

	// Controller write lands only in a cycle without host write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			upstart_q <= 1'b0;
			upend_q   <= 1'b0;
			frames_q  <= '0;
		end else if (host_wr) begin
			// Writes to REG_FRAMES are ignored
			if (host_addr == REG_CTRL) begin
				upstart_q <= host_wdata[CTRL_UPSTART_BIT];
				upend_q   <= host_wdata[CTRL_UPEND_BIT];
			end
		end else if (crf.wrt && crf.waddr == REG_CTRL) begin
			upstart_q <= crf.wdata[CTRL_UPSTART_BIT];
			upend_q   <= crf.wdata[CTRL_UPEND_BIT];
			// Count a frame each time UPEND is written back
			if (crf.wdata[CTRL_UPEND_BIT])
				frames_q <= frames_q + 1'b1;
		end
	end

	// REG_CTRL as seen by the host
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_UPSTART_BIT] = upstart_q;
		ctrl_word[CTRL_UPEND_BIT]   = upend_q;
	end

	// Combinational read, unmapped addresses give zero
	always_comb begin
		case (host_addr)
			REG_CTRL:   host_rdata = ctrl_word;
			REG_FRAMES: host_rdata = frames_q;
			default:    host_rdata = '0;
		endcase
	end

	assign crf.upstart = upstart_q;
	assign crf.upend   = upend_q;

endmodule

//--- hw/crf_if.sv
// Write strobe is single-cycle and may be dropped by the register file when the host writes
`timescale 1ns/100ps

interface crf_if;
	import upsp_pkg::*;

	// Current start/end flags from REG_CTRL
	logic      upstart;
	logic      upend;

	// Controller write-back port
	logic      wrt;
	crf_addr_t waddr;
	crf_data_t wdata;

	// Register file side
	modport regs (
		output upstart,
		output upend,
		input  wrt,
		input  waddr,
		input  wdata
	);

	// Controller side
	modport ctrl (
		input  upstart,
		input  upend,
		output wrt,
		output waddr,
		output wdata
	);

endinterface

//--- hw/out_buffer.sv
// DEPTH must be a power of two; rd is assumed only when the FIFO is not empty
`timescale 1ns/100ps

module out_buffer #(
	parameter int DEPTH = upsp_pkg::FIFO_DEPTH
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            frame_clear,
	input  logic            wvalid,
	output logic            wready,
	input  upsp_pkg::word_t wdata,
	input  logic            rd,
	output upsp_pkg::word_t rdata,
	output logic            empty
);
	import upsp_pkg::*;

	word_t                    mem [DEPTH];
	// Pointers carry one wrap bit above the address
	logic [$clog2(DEPTH):0]   wptr;
	logic [$clog2(DEPTH):0]   rptr;
	logic                     full;
	logic                     push;

	assign empty  = (wptr == rptr);
	// Same address, opposite wrap bit
	assign full   = (wptr[$clog2(DEPTH)] != rptr[$clog2(DEPTH)]) &&
	                (wptr[$clog2(DEPTH)-1:0] == rptr[$clog2(DEPTH)-1:0]);
	assign wready = !full;
	assign push   = wvalid && wready;

	// Pointer update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else if (frame_clear) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push)
				wptr <= wptr + 1'b1;
			if (rd)
				rptr <= rptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wptr[$clog2(DEPTH)-1:0]] <= wdata;
	end

	// Head word, shown without a read
	assign rdata = mem[rptr[$clog2(DEPTH)-1:0]];

endmodule

//--- hw/stream_in.sv
// Takes exactly SRC_FRAME_WORDS words per frame; input tlast is not checked against the count
`timescale 1ns/100ps

module stream_in (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            window,
	input  logic            frame_clear,
	input  logic            s_axis_tvalid,
	output logic            s_axis_tready,
	input  upsp_pkg::word_t s_axis_tdata,
	input  logic            s_axis_tlast,
	output logic            src_valid,
	input  logic            src_ready,
	output upsp_pkg::word_t src_data
);
	import upsp_pkg::*;

	logic     hold_valid;
	word_t    hold_data;
	src_cnt_t taken;
	logic     take;

	// Ready only with a free slot and words left in the frame.
	// Frame length comes from the count, so tlast has no effect here
	assign s_axis_tready = window && !hold_valid && (taken < src_cnt_t'(SRC_FRAME_WORDS));
	assign take          = s_axis_tvalid && s_axis_tready;

	// Holding register control and word count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
			taken      <= '0;
		end else if (frame_clear) begin
			hold_valid <= 1'b0;
			taken      <= '0;
		end else if (take) begin
			hold_valid <= 1'b1;
			taken      <= taken + 1'b1;
		end else if (src_ready) begin
			hold_valid <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (take)
			hold_data <= s_axis_tdata;
	end

	assign src_valid = hold_valid;
	assign src_data  = hold_data;

endmodule

//--- hw/stream_out.sv
// tlast every DST_WORDS_PER_ROW beats; frame_done assumes exactly DST_FRAME_WORDS per frame
`timescale 1ns/100ps

module stream_out (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            window,
	input  logic            frame_clear,
	input  logic            empty,
	output logic            rd,
	input  upsp_pkg::word_t rdata,
	output logic            m_axis_tvalid,
	input  logic            m_axis_tready,
	output upsp_pkg::word_t m_axis_tdata,
	output logic            m_axis_tlast,
	output logic            frame_done
);
	import upsp_pkg::*;

	dst_cnt_t beat_cnt;
	dst_cnt_t next_cnt;
	logic     row_end;
	logic     frame_end;
	logic     final_q;

	// Pop when output register is free or being drained
	assign rd = !empty && window && (!m_axis_tvalid || m_axis_tready);

	// Beat number of the word being popped
	assign next_cnt  = beat_cnt + 1'b1;
	assign row_end   = (next_cnt % dst_cnt_t'(DST_WORDS_PER_ROW)) == '0;
	assign frame_end = (next_cnt == dst_cnt_t'(DST_FRAME_WORDS));

	// Output register control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
			final_q       <= 1'b0;
			beat_cnt      <= '0;
		end else if (frame_clear) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
			final_q       <= 1'b0;
			beat_cnt      <= '0;
		end else if (rd) begin
			m_axis_tvalid <= 1'b1;
			m_axis_tlast  <= row_end;
			final_q       <= frame_end;
			beat_cnt      <= next_cnt;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
			final_q       <= 1'b0;
		end
	end

	// Data holds under back-pressure since rd is low then
	always_ff @(posedge clk) begin
		if (rd)
			m_axis_tdata <= rdata;
	end

	// Last beat of the frame accepted
	assign frame_done = m_axis_tvalid && m_axis_tready && final_q;

endmodule

//--- hw/upsampler.sv
// 2x nearest-neighbour only; one source row buffered, next row taken after both copies leave
`timescale 1ns/100ps

module upsampler (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            frame_clear,
	input  logic            src_valid,
	output logic            src_ready,
	input  upsp_pkg::word_t src_data,
	output logic            wvalid,
	input  logic            wready,
	output upsp_pkg::word_t wdata
);
	import upsp_pkg::*;

	// Line buffer, entry 0 is the word being replicated
	word_t    line_buf [SRC_WORDS_PER_ROW];
	src_cnt_t fill_cnt;
	dst_cnt_t emit_cnt;
	logic     row_full;
	logic     last_emit;
	logic     load;
	logic     emit;
	pixel_t   pix_a;
	pixel_t   pix_b;

	assign row_full  = (fill_cnt == src_cnt_t'(SRC_WORDS_PER_ROW));
	// Two copies of a destination row
	assign last_emit = (emit_cnt == dst_cnt_t'(2 * DST_WORDS_PER_ROW - 1));

	assign src_ready = !row_full;
	assign wvalid    = row_full;
	assign load      = src_valid && src_ready;
	assign emit      = wvalid && wready;

	// Fill, then emit both copies of the row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_cnt <= '0;
			emit_cnt <= '0;
		end else if (frame_clear) begin
			fill_cnt <= '0;
			emit_cnt <= '0;
		end else if (load) begin
			fill_cnt <= fill_cnt + 1'b1;
		end else if (emit) begin
			if (last_emit) begin
				fill_cnt <= '0;
				emit_cnt <= '0;
			end else begin
				emit_cnt <= emit_cnt + 1'b1;
			end
		end
	end

	// Shift in while filling; rotate after each source word's second half,
	// so a full copy brings the row back to its start
	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < SRC_WORDS_PER_ROW - 1; i++)
				line_buf[i] <= line_buf[i+1];
			line_buf[SRC_WORDS_PER_ROW-1] <= src_data;
		end else if (emit && emit_cnt[0]) begin
			for (int i = 0; i < SRC_WORDS_PER_ROW - 1; i++)
				line_buf[i] <= line_buf[i+1];
			line_buf[SRC_WORDS_PER_ROW-1] <= line_buf[0];
		end
	end

	// Even beat takes p0/p1, odd beat p2/p3
	always_comb begin
		if (emit_cnt[0]) begin
			pix_a = line_buf[0][2*$bits(pixel_t) +: $bits(pixel_t)];
			pix_b = line_buf[0][3*$bits(pixel_t) +: $bits(pixel_t)];
		end else begin
			pix_a = line_buf[0][0 +: $bits(pixel_t)];
			pix_b = line_buf[0][$bits(pixel_t) +: $bits(pixel_t)];
		end
		// Each pixel doubled horizontally
		wdata = {pix_b, pix_b, pix_a, pix_a};
	end

endmodule

//--- hw/upsp_pkg.sv
// Fixed 8x4 source / 16x8 destination geometry; 2x nearest-neighbour only, no scaling options
package upsp_pkg;

	// Image geometry, four 8-bit pixels per stream word
	localparam int PIX_PER_WORD      = 4;
	localparam int SRC_W             = 8;
	localparam int SRC_H             = 4;
	localparam int DST_W             = 2 * SRC_W;
	localparam int DST_H             = 2 * SRC_H;
	localparam int SRC_WORDS_PER_ROW = SRC_W / PIX_PER_WORD;
	localparam int DST_WORDS_PER_ROW = DST_W / PIX_PER_WORD;
	localparam int SRC_FRAME_WORDS   = SRC_WORDS_PER_ROW * SRC_H;
	localparam int DST_FRAME_WORDS   = DST_WORDS_PER_ROW * DST_H;

	// Output FIFO default depth
	localparam int FIFO_DEPTH = 8;

	// Pixel 0 sits in the low byte of a word
	typedef logic [7:0] pixel_t;
	typedef logic [PIX_PER_WORD*$bits(pixel_t)-1:0] word_t;

	// Register link
	typedef logic [1:0]  crf_addr_t;
	typedef logic [31:0] crf_data_t;

	// Frame counters, one spare value for the "all taken" state
	typedef logic [$clog2(SRC_FRAME_WORDS+1)-1:0] src_cnt_t;
	typedef logic [$clog2(DST_FRAME_WORDS+1)-1:0] dst_cnt_t;

	// Register map
	localparam crf_addr_t REG_CTRL   = 2'd0;
	localparam crf_addr_t REG_FRAMES = 2'd1;

	// Bit positions inside REG_CTRL
	localparam int CTRL_UPSTART_BIT = 0;
	localparam int CTRL_UPEND_BIT   = 1;

	// Controller FSM
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} ac_state_t;

endpackage

//--- hw/upsp_top.sv
// Fixed-size frames started by REG_CTRL writes; no tkeep/tstrb/tid/tdest/user sidebands
`timescale 1ns/100ps

module upsp_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                host_wr,
	input  upsp_pkg::crf_addr_t host_addr,
	input  upsp_pkg::crf_data_t host_wdata,
	output upsp_pkg::crf_data_t host_rdata,
	output logic                busy,
	input  logic                s_axis_tvalid,
	output logic                s_axis_tready,
	input  upsp_pkg::word_t     s_axis_tdata,
	input  logic                s_axis_tlast,
	output logic                m_axis_tvalid,
	input  logic                m_axis_tready,
	output upsp_pkg::word_t     m_axis_tdata,
	output logic                m_axis_tlast
);
	import upsp_pkg::*;

	logic  window;
	logic  frame_clear;
	logic  frame_done;
	logic  src_valid;
	logic  src_ready;
	word_t src_data;
	logic  up_wvalid;
	logic  up_wready;
	word_t up_wdata;
	logic  ob_empty;
	logic  ob_rd;
	word_t ob_rdata;

	// Register link
	crf_if crf0 ();

	config_regs regs0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_wr    (host_wr),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.crf        (crf0)
	);

	access_control ctrl0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.crf         (crf0),
		.frame_done  (frame_done),
		.window      (window),
		.frame_clear (frame_clear),
		.busy        (busy)
	);

	stream_in sin0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.window        (window),
		.frame_clear   (frame_clear),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tlast  (s_axis_tlast),
		.src_valid     (src_valid),
		.src_ready     (src_ready),
		.src_data      (src_data)
	);

	upsampler ups0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_clear (frame_clear),
		.src_valid   (src_valid),
		.src_ready   (src_ready),
		.src_data    (src_data),
		.wvalid      (up_wvalid),
		.wready      (up_wready),
		.wdata       (up_wdata)
	);

	out_buffer #(
		.DEPTH (FIFO_DEPTH)
	) obuf0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_clear (frame_clear),
		.wvalid      (up_wvalid),
		.wready      (up_wready),
		.wdata       (up_wdata),
		.rd          (ob_rd),
		.rdata       (ob_rdata),
		.empty       (ob_empty)
	);

	stream_out sout0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.window        (window),
		.frame_clear   (frame_clear),
		.empty         (ob_empty),
		.rd            (ob_rd),
		.rdata         (ob_rdata),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast),
		.frame_done    (frame_done)
	);

endmodule

//--- run.sh
#!/bin/sh
# Build and run with Verilator; the result comes from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_upsp -f compile.f -o tb_upsp \
	> build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_upsp > sim.log 2>&1
grep -q "All tests passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

//--- testbench/tb_upsp.sv
// One frame in flight at a time; host writes never overlap a frame, tlast on input is not checked
`timescale 1ns/100ps

module tb_upsp;
	import upsp_pkg::*;

	// Cycle limits for the polling loops
	localparam int FRAME_TIMEOUT  = 2000;
	localparam int STATUS_TIMEOUT = 20;
	localparam int BUSY_TIMEOUT   = 10;
	// REG_CTRL after write-back has UPEND set and UPSTART clear
	localparam crf_data_t CTRL_DONE = 32'd2;

	logic      clk;
	logic      rst_n;
	logic      host_wr;
	crf_addr_t host_addr;
	crf_data_t host_wdata;
	crf_data_t host_rdata;
	logic      busy;
	logic      s_axis_tvalid;
	logic      s_axis_tready;
	word_t     s_axis_tdata;
	logic      s_axis_tlast;
	logic      m_axis_tvalid;
	logic      m_axis_tready;
	word_t     m_axis_tdata;
	logic      m_axis_tlast;
	integer    seed;
	crf_data_t rd_val;

	upsp_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.host_wr       (host_wr),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_rdata    (host_rdata),
		.busy          (busy),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tlast  (s_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_last(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_reg(input string name, input crf_data_t exp, input crf_data_t act);
		if (act !== exp)
			stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// Single-cycle host write
	task automatic write_reg(input crf_addr_t addr, input crf_data_t data);
		@(posedge clk);
		#1;
		host_wr    = 1'b1;
		host_addr  = addr;
		host_wdata = data;
		@(posedge clk);
		#1;
		host_wr = 1'b0;
	endtask

	// Read is combinational and sampled mid-cycle
	task automatic read_reg(input crf_addr_t addr, output crf_data_t data);
		@(posedge clk);
		#1;
		host_addr = addr;
		@(negedge clk);
		data = host_rdata;
	endtask

	// Input offered with no frame running
	task automatic offer_closed_window();
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b1;
		s_axis_tdata  = $random(seed);
		for (int i = 0; i < 6; i++) begin
			@(negedge clk);
			check_flag("closed window tready", 1'b0, s_axis_tready);
		end
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
	endtask

	// Write UPSTART and wait for the controller to leave IDLE
	task automatic start_frame();
		int waited;
		waited = 0;
		write_reg(REG_CTRL, 32'd1);
		@(negedge clk);
		while (busy !== 1'b1) begin
			if (waited == BUSY_TIMEOUT)
				stop_on_error("Timeout: busy never rose after UPSTART was written");
			waited++;
			@(negedge clk);
		end
	endtask

	// Sends a random source frame and checks the replicated output beat by beat
	task automatic run_frame(input string name);
		word_t       src [SRC_FRAME_WORDS];
		word_t       expd [DST_FRAME_WORDS];
		word_t       sw;
		word_t       held_data;
		logic        held_last;
		logic        stalled;
		logic        in_take;
		logic        out_take;
		logic [31:0] r;
		int          n;
		int          sent;
		int          got;
		int          cycles;
		string       tag;
		for (int i = 0; i < SRC_FRAME_WORDS; i++)
			src[i] = $random(seed);
		// Model repeats each source row twice with each pixel doubled
		n = 0;
		for (int row = 0; row < SRC_H; row++)
			for (int copy = 0; copy < 2; copy++)
				for (int w = 0; w < SRC_WORDS_PER_ROW; w++) begin
					sw = src[row*SRC_WORDS_PER_ROW + w];
					expd[n] = {sw[15:8], sw[15:8], sw[7:0], sw[7:0]};
					expd[n+1] = {sw[31:24], sw[31:24], sw[23:16], sw[23:16]};
					n = n + 2;
				end
		sent     = 0;
		got      = 0;
		cycles   = 0;
		in_take  = 1'b0;
		stalled  = 1'b0;
		while (got < DST_FRAME_WORDS) begin
			if (cycles == FRAME_TIMEOUT)
				stop_on_error($sformatf("Timeout: %s output stopped after %0d beats", name, got));
			cycles++;
			@(posedge clk);
			#1;
			if (in_take)
				sent++;
			// Valid stays up until taken so gaps fall only between words
			if (in_take || !s_axis_tvalid) begin
				r = $random(seed);
				s_axis_tvalid = (sent < SRC_FRAME_WORDS) && (r[1:0] != 2'd0);
				if (sent < SRC_FRAME_WORDS) begin
					s_axis_tdata = src[sent];
					s_axis_tlast = (sent == SRC_FRAME_WORDS - 1);
				end
			end
			r = $random(seed);
			m_axis_tready = (r[3:2] != 2'd0);
			@(negedge clk);
			tag = $sformatf("%s beat %0d", name, got);
			// Stalled beat must not change
			if (stalled) begin
				check_flag({tag, " held tvalid"}, 1'b1, m_axis_tvalid);
				check_word({tag, " held tdata"}, held_data, m_axis_tdata);
				check_last({tag, " held tlast"}, held_last, m_axis_tlast);
			end
			in_take   = s_axis_tvalid && s_axis_tready;
			out_take  = m_axis_tvalid && m_axis_tready;
			stalled   = m_axis_tvalid && !m_axis_tready;
			held_data = m_axis_tdata;
			held_last = m_axis_tlast;
			if (out_take) begin
				check_word({tag, " tdata"}, expd[got], m_axis_tdata);
				check_last({tag, " tlast"},
				           (got % DST_WORDS_PER_ROW) == DST_WORDS_PER_ROW - 1, m_axis_tlast);
				got++;
			end
		end
	endtask

	// Poll for UPEND and check the whole status and frame count
	task automatic check_status(input string name, input crf_data_t exp_frames);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		host_addr     = REG_CTRL;
		@(negedge clk);
		while (host_rdata[CTRL_UPEND_BIT] !== 1'b1) begin
			if (m_axis_tvalid)
				stop_on_error($sformatf("Extra output beat after the end of %s", name));
			if (waited == STATUS_TIMEOUT)
				stop_on_error($sformatf("Timeout: REG_CTRL write-back for %s never came", name));
			waited++;
			@(negedge clk);
		end
		check_reg({name, " REG_CTRL"}, CTRL_DONE, host_rdata);
		check_flag({name, " busy"}, 1'b0, busy);
		read_reg(REG_FRAMES, rd_val);
		check_reg({name, " REG_FRAMES"}, exp_frames, rd_val);
		// Output stays quiet with tready up
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_flag({name, " idle tvalid"}, 1'b0, m_axis_tvalid);
		end
	endtask

	initial begin
		seed          = 32'he6d3;
		rst_n         = 1'b0;
		host_wr       = 1'b0;
		host_addr     = REG_CTRL;
		host_wdata    = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tlast  = 1'b0;
		m_axis_tready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle outputs and cleared registers
		@(negedge clk);
		check_flag("reset tready", 1'b0, s_axis_tready);
		check_flag("reset tvalid", 1'b0, m_axis_tvalid);
		check_flag("reset busy", 1'b0, busy);
		read_reg(REG_CTRL, rd_val);
		check_reg("reset REG_CTRL", 32'd0, rd_val);
		read_reg(REG_FRAMES, rd_val);
		check_reg("reset REG_FRAMES", 32'd0, rd_val);
		offer_closed_window();

		start_frame();
		run_frame("frame 1");
		check_status("frame 1", 32'd1);

		// Clear REG_CTRL before the next start
		write_reg(REG_CTRL, 32'd0);
		start_frame();
		run_frame("frame 2");
		check_status("frame 2", 32'd2);

		$display("All tests passed");
		$finish;
	end

endmodule
